// ==== rtl/cpu_bus_port.sv ====
/*
 * CPU bus port
 * Four-phase req/ack slave. Captures a bus cycle, launches it to
 * the decoder and returns the read word with ack
 */
`default_nettype none

module cpu_bus_port (
    input  logic                clk,
    input  logic                rst,
    input  logic                req,
    output logic                ack,
    input  s16_bus_pkg::addr_t  addr,
    input  logic                rnw,
    input  s16_bus_pkg::dsn_t   dsn,
    input  s16_bus_pkg::data_t  wdata,
    output s16_bus_pkg::data_t  rdata,
    cycle_if.host               cyc
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_ACKED
    } state_e;

    state_e state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ST_IDLE;
            ack       <= 1'b0;
            cyc.valid <= 1'b0;
            rdata     <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req) begin
                        cyc.valid <= 1'b1;
                        state     <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    // Decoder finished, return data and acknowledge
                    if (cyc.done) begin
                        cyc.valid <= 1'b0;
                        rdata     <= cyc.rdata;
                        ack       <= 1'b1;
                        state     <= ST_ACKED;
                    end
                end
                ST_ACKED: begin
                    // Wait for the master to release req
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Cycle attributes, stable while valid is high
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req) begin
            cyc.addr.raw <= addr;
            cyc.rnw      <= rnw;
            cyc.dsn      <= dsn;
            cyc.wdata    <= wdata;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/cycle_if.sv ====
/*
 * Bus cycle link
 * Carries one captured CPU cycle to the region decoder and its
 * completion and read data back
 */
`default_nettype none

interface cycle_if;
    import s16_bus_pkg::*;
    import s16_map_pkg::*;

    logic      valid;
    bus_addr_u addr;
    logic      rnw;
    dsn_t      dsn;
    data_t     wdata;
    logic      done;
    data_t     rdata;

    modport host (
        output valid, addr, rnw, dsn, wdata,
        input  done, rdata
    );

    modport target (
        input  valid, addr, rnw, dsn, wdata,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== rtl/dev_if.sv ====
/*
 * Device request link
 * Region decoder hands a select vector and ROM address to the
 * device port, which answers with done and the read word
 */
`default_nettype none

interface dev_if;
    import s16_bus_pkg::*;
    import s16_map_pkg::*;

    // One cycle pulse per request
    logic      start;
    // Held from start until done
    dev_sel_t  sel;
    rom_addr_t rom_addr;

    // One cycle pulse, rdata valid with it
    logic      done;
    data_t     rdata;

    modport ctrl (
        output start, sel, rom_addr,
        input  done, rdata
    );

    modport dev (
        input  start, sel, rom_addr,
        output done, rdata
    );

endinterface

`default_nettype wire

// ==== rtl/device_port.sv ====
/*
 * Device port
 * Drives the chip selects, waits on the memory ready signals or a
 * fixed count and registers the read data mux
 */
`default_nettype none

module device_port #(
    parameter int FIXED_WAIT = 1
) (
    input  logic                    clk,
    input  logic                    rst,
    dev_if.dev                      dev,
    output logic                    rom_cs,
    output logic                    ram_cs,
    output logic                    vram_cs,
    output logic                    char_cs,
    output logic                    objram_cs,
    output logic                    pal_cs,
    output logic                    io_cs,
    output s16_bus_pkg::rom_addr_t  rom_addr,
    input  s16_bus_pkg::data_t      rom_data,
    input  s16_bus_pkg::data_t      ram_data,
    input  s16_bus_pkg::data_t      char_dout,
    input  s16_bus_pkg::data_t      obj_dout,
    input  s16_bus_pkg::data_t      pal_dout,
    input  logic [7:0]              io_dout,
    input  logic                    rom_ok,
    input  logic                    ram_ok
);

    import s16_bus_pkg::*;
    import s16_map_pkg::*;

    localparam int CNT_W = (FIXED_WAIT > 1) ? $clog2(FIXED_WAIT) : 1;
    localparam logic [CNT_W-1:0] WAIT_LAST = CNT_W'(FIXED_WAIT - 1);

    dev_sel_t         cs_q;
    logic [CNT_W-1:0] wait_cnt;
    logic             fixed_cs;
    logic             empty;
    logic             finish;
    data_t            read_mux;

    assign rom_cs    = cs_q.rom;
    assign ram_cs    = cs_q.ram;
    assign vram_cs   = cs_q.vram;
    assign char_cs   = cs_q.chr;
    assign objram_cs = cs_q.objram;
    assign pal_cs    = cs_q.pal;
    assign io_cs     = cs_q.io;
    assign rom_addr  = dev.rom_addr;

    assign fixed_cs = char_cs || objram_cs || pal_cs || io_cs;
    assign empty    = dev.sel == '0;

    // Late ok just keeps the select high
    assign finish = (rom_cs && rom_ok)
                 || ((ram_cs || vram_cs) && ram_ok)
                 || (fixed_cs && wait_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cs_q     <= '0;
            wait_cnt <= '0;
            dev.done <= 1'b0;
        end else begin
            dev.done <= 1'b0;
            if (dev.start) begin
                cs_q     <= dev.sel;
                wait_cnt <= WAIT_LAST;
                // Nothing selected, complete right away
                dev.done <= empty;
            end else if (finish) begin
                cs_q     <= '0;
                dev.done <= 1'b1;
            end else if (fixed_cs) begin
                wait_cnt <= wait_cnt - 1'b1;
            end
        end
    end

    always_comb begin
        if (ram_cs || vram_cs) begin
            read_mux = ram_data;
        end else if (rom_cs) begin
            read_mux = rom_data;
        end else if (char_cs) begin
            read_mux = char_dout;
        end else if (pal_cs) begin
            read_mux = pal_dout;
        end else if (objram_cs) begin
            read_mux = obj_dout;
        end else if (io_cs) begin
            read_mux = {8'hff, io_dout};
        end else begin
            read_mux = OPEN_BUS;
        end
    end

    always_ff @(posedge clk) begin
        if (dev.start && empty) begin
            dev.rdata <= OPEN_BUS;
        end else if (finish) begin
            dev.rdata <= read_mux;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/region_decode.sv ====
/*
 * Region decoder
 * Maps each cycle to a device select, forms the banked ROM address,
 * holds the tile bank register and drives the shared device bus
 */
`default_nettype none

module region_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  s16_map_pkg::board_e      board,
    cycle_if.target                  cyc,
    dev_if.ctrl                      dev,
    output s16_bus_pkg::tile_bank_t  tile_bank,
    output logic [11:0]              bus_addr,
    output logic                     bus_rnw,
    output s16_bus_pkg::dsn_t        bus_dsn,
    output s16_bus_pkg::data_t       bus_dout
);

    import s16_bus_pkg::*;
    import s16_map_pkg::*;

    logic      busy;
    logic      launch;
    logic      strobe;
    logic      tbank_wr;
    logic [1:0] bank;
    region_t   region;
    dev_sel_t  next_sel;
    rom_addr_t next_rom_addr;

    assign launch   = cyc.valid && !busy;
    assign region   = cyc.addr.f.region;
    assign strobe   = cyc.dsn != 2'b11;
    assign bank     = region[1:0];
    assign tbank_wr = region == REG_ROM2 && !cyc.rnw && !cyc.dsn[0];

    always_comb begin
        next_sel = '0;
        case (region)
            REG_ROM0, REG_ROM1, REG_ROM2: next_sel.rom = cyc.rnw;
            REG_RAM:  next_sel.ram    = strobe;
            REG_ORAM: next_sel.objram = 1'b1;
            REG_VRAM: begin
                // Bit 16 splits text RAM from tile RAM
                next_sel.chr  = cyc.addr.f.sel16;
                next_sel.vram = !cyc.addr.f.sel16 && strobe;
            end
            REG_PAL:  next_sel.pal = 1'b1;
            REG_IO:   next_sel.io  = 1'b1;
            default:  next_sel = '0;
        endcase
    end

    // ROM banking per board type
    always_comb begin
        case (board)
            BOARD_5358L:  next_rom_addr = {bank, cyc.addr.raw[16:1]};
            BOARD_5358S:  next_rom_addr = {1'b0, bank, cyc.addr.raw[15:1]};
            BOARD_KOREAN: next_rom_addr = {1'b0, cyc.addr.raw[17:1]};
            default:      next_rom_addr = {bank[0], cyc.addr.raw[17:1]};
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            dev.start <= 1'b0;
            dev.sel   <= '0;
            tile_bank <= '0;
        end else begin
            dev.start <= launch;
            if (launch) begin
                busy    <= 1'b1;
                dev.sel <= next_sel;
            end else if (dev.done) begin
                busy    <= 1'b0;
                dev.sel <= '0;
            end
            // A1 picks the upper half
            if (launch && tbank_wr) begin
                if (cyc.addr.raw[1]) begin
                    tile_bank[5:3] <= cyc.wdata[2:0];
                end else begin
                    tile_bank[2:0] <= cyc.wdata[2:0];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            dev.rom_addr <= next_rom_addr;
        end
    end

    assign cyc.done  = dev.done;
    assign cyc.rdata = dev.rdata;

    // Shared bus, write strobes only active during a write cycle
    assign bus_addr = cyc.addr.raw[12:1];
    assign bus_rnw  = cyc.rnw || !cyc.valid;
    assign bus_dsn  = cyc.dsn | {2{bus_rnw}};
    assign bus_dout = cyc.wdata;

endmodule

`default_nettype wire

// ==== rtl/s16_bus_pkg.sv ====
/*
 * System 16B bus package
 * Widths and types of the main CPU data path, strobes and banking
 */
`default_nettype none

package s16_bus_pkg;

    // CPU word address, A0 is implied by the strobes
    typedef logic [23:1] addr_t;

    typedef logic [15:0] data_t;

    // Active low, bit 1 is UDS and bit 0 is LDS
    typedef logic [1:0] dsn_t;

    // Program ROM word address after banking
    typedef logic [18:1] rom_addr_t;

    // Upper half in 5:3, lower half in 2:0
    typedef logic [5:0] tile_bank_t;

    // Read value when nothing drives the bus
    localparam data_t OPEN_BUS = 16'hffff;

endpackage

`default_nettype wire

// ==== rtl/s16_main_bus.sv ====
/*
 * System 16B main bus controller
 * Req/ack CPU port, region decoder and device port
 */
`default_nettype none

module s16_main_bus #(
    parameter int FIXED_WAIT = 1
) (
    input  logic                     clk,
    input  logic                     rst,

    // Bus master
    input  logic                     req,
    output logic                     ack,
    input  s16_bus_pkg::addr_t       addr,
    input  logic                     rnw,
    input  s16_bus_pkg::dsn_t        dsn,
    input  s16_bus_pkg::data_t       wdata,
    output s16_bus_pkg::data_t       rdata,

    input  s16_map_pkg::board_e      board,

    // Device selects and data
    output logic                     rom_cs,
    output logic                     ram_cs,
    output logic                     vram_cs,
    output logic                     char_cs,
    output logic                     objram_cs,
    output logic                     pal_cs,
    output logic                     io_cs,
    output s16_bus_pkg::rom_addr_t   rom_addr,
    input  s16_bus_pkg::data_t       rom_data,
    input  s16_bus_pkg::data_t       ram_data,
    input  s16_bus_pkg::data_t       char_dout,
    input  s16_bus_pkg::data_t       obj_dout,
    input  s16_bus_pkg::data_t       pal_dout,
    input  logic [7:0]               io_dout,
    input  logic                     rom_ok,
    input  logic                     ram_ok,

    // Shared device bus
    output s16_bus_pkg::tile_bank_t  tile_bank,
    output logic [11:0]              bus_addr,
    output logic                     bus_rnw,
    output s16_bus_pkg::dsn_t        bus_dsn,
    output s16_bus_pkg::data_t       bus_dout
);

    cycle_if u_cyc ();
    dev_if   u_dev ();

    cpu_bus_port u_cpu_bus_port (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .ack   (ack),
        .addr  (addr),
        .rnw   (rnw),
        .dsn   (dsn),
        .wdata (wdata),
        .rdata (rdata),
        .cyc   (u_cyc.host)
    );

    region_decode u_region_decode (
        .clk       (clk),
        .rst       (rst),
        .board     (board),
        .cyc       (u_cyc.target),
        .dev       (u_dev.ctrl),
        .tile_bank (tile_bank),
        .bus_addr  (bus_addr),
        .bus_rnw   (bus_rnw),
        .bus_dsn   (bus_dsn),
        .bus_dout  (bus_dout)
    );

    device_port #(
        .FIXED_WAIT (FIXED_WAIT)
    ) u_device_port (
        .clk       (clk),
        .rst       (rst),
        .dev       (u_dev.dev),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .obj_dout  (obj_dout),
        .pal_dout  (pal_dout),
        .io_dout   (io_dout),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok)
    );

endmodule

`default_nettype wire

// ==== rtl/s16_map_pkg.sv ====
/*
 * System 16B memory map package
 * Region numbers, board types, the select vector and the two
 * views of a CPU bus address
 */
`default_nettype none

package s16_map_pkg;

    // Region index comes from address bits 23:21
    typedef enum logic [2:0] {
        REG_ROM0 = 3'd0,
        REG_ROM1 = 3'd1,
        REG_ROM2 = 3'd2,
        REG_RAM  = 3'd3,
        REG_ORAM = 3'd4,
        REG_VRAM = 3'd5,
        REG_PAL  = 3'd6,
        REG_IO   = 3'd7
    } region_t;

    typedef enum logic [1:0] {
        BOARD_5521   = 2'd0,
        BOARD_5358S  = 2'd1,
        BOARD_5358L  = 2'd2,
        BOARD_KOREAN = 2'd3
    } board_e;

    // Field view of a word address
    typedef struct packed {
        region_t     region;
        logic [3:0]  page;     // bits 20:17
        logic        sel16;    // text RAM when set, tile RAM when clear
        logic [15:1] offset;
    } addr_fields_t;

    // Same word seen raw for ROM banking or split into fields
    typedef union packed {
        s16_bus_pkg::addr_t raw;
        addr_fields_t       f;
    } bus_addr_u;

    // One bit per external device select
    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic objram;
        logic pal;
        logic io;
    } dev_sel_t;

endpackage

`default_nettype wire

// ==== tb.f ====
+incdir+test
rtl/s16_bus_pkg.sv
rtl/s16_map_pkg.sv
rtl/cycle_if.sv
rtl/dev_if.sv
rtl/cpu_bus_port.sv
rtl/region_decode.sv
rtl/device_port.sv
rtl/s16_main_bus.sv
test/tb_s16_main_bus.sv

// ==== test/s16_bus_tasks.svh ====
/*
 * Bus cycle and directed test tasks for the main bus testbench
 * Included inside the testbench module
 */
`ifndef S16_BUS_TASKS_SVH
`define S16_BUS_TASKS_SVH

// Selects as {rom, ram, vram, char, objram, pal, io}
function automatic logic [6:0] cs_now();
    return {rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs};
endfunction

function automatic addr_t rand_addr(input logic [2:0] region);
    logic [19:0] low;
    low = 20'($urandom());
    return {region, low};
endfunction

function automatic logic [6:0] expect_sel(input addr_t a, input logic r, input dsn_t d);
    logic       strobe;
    logic [6:0] sel;
    strobe = d != 2'b11;
    case (a[23:21])
        REG_ROM0, REG_ROM1, REG_ROM2: sel = r ? 7'b100_0000 : 7'b000_0000;
        REG_RAM:  sel = strobe ? 7'b010_0000 : 7'b000_0000;
        REG_ORAM: sel = 7'b000_0100;
        // Bit 16 set is text RAM and tile RAM needs a strobe
        REG_VRAM: sel = a[16] ? 7'b000_1000 : (strobe ? 7'b001_0000 : 7'b000_0000);
        REG_PAL:  sel = 7'b000_0010;
        default:  sel = 7'b000_0001;
    endcase
    return sel;
endfunction

function automatic rom_addr_t expect_rom_addr(input board_e b, input addr_t a);
    logic [1:0] bank;
    bank = a[22:21];
    case (b)
        BOARD_5521:  return {bank[0], a[17:1]};
        BOARD_5358L: return {bank, a[16:1]};
        BOARD_5358S: return {1'b0, bank, a[15:1]};
        default:     return {1'b0, a[17:1]};
    endcase
endfunction

function automatic data_t expect_rdata(input addr_t a, input logic [6:0] sel);
    data_t word;
    case (sel)
        7'b100_0000: word = rom_word(expect_rom_addr(board, a));
        7'b010_0000, 7'b001_0000: word = {TAG_RAM, a[12:1]};
        7'b000_1000: word = {TAG_CHAR, a[12:1]};
        7'b000_0100: word = {TAG_OBJ, a[12:1]};
        7'b000_0010: word = {TAG_PAL, a[12:1]};
        7'b000_0001: word = {8'hff, io_byte(a[12:1])};
        default:     word = OPEN_BUS;
    endcase
    return word;
endfunction

task automatic check_value(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    n_checks++;
    assert (actual === expected) else begin
        n_errors++;
        $display("error %s: %s expected 0x%0h, actual 0x%0h",
                 cur_test, what, expected, actual);
    end
endtask

// Full four-phase exchange that samples the selects, ROM address and shared bus
task automatic bus_cycle(input addr_t a, input logic r, input dsn_t d, input data_t wd);
    int hold;
    last_seen      = '0;
    last_rom_addr  = '0;
    last_cycles    = 0;
    last_cs_cycles = 0;
    last_bus_rnw   = 1'bx;
    last_bus_dsn   = 'x;
    last_bus_dout  = 'x;
    @(posedge clk);
    #(DRIVE_DLY);
    assert (!ack) else begin
        n_errors++;
        $display("%s: ack still high before req was raised", cur_test);
    end
    addr  = a;
    rnw   = r;
    dsn   = d;
    wdata = wd;
    req   = 1'b1;
    while (!ack) begin
        @(posedge clk);
        #(DRIVE_DLY);
        last_cycles++;
        assert ($countones(cs_now()) <= 1) else begin
            n_errors++;
            $display("%s: more than one chip select high at once", cur_test);
        end
        if (cs_now() != '0) begin
            last_cs_cycles++;
        end
        last_seen |= cs_now();
        if (rom_cs) begin
            last_rom_addr = rom_addr;
        end
        // Shared bus while the cycle is still open
        if (!ack) begin
            last_bus_rnw  = bus_rnw;
            last_bus_dsn  = bus_dsn;
            last_bus_dout = bus_dout;
        end
    end
    last_rdata = rdata;
    // Master keeps req a little longer while ack and rdata hold
    hold = $urandom_range(2, 0);
    repeat (hold) begin
        @(posedge clk);
        #(DRIVE_DLY);
        assert (ack && rdata === last_rdata) else begin
            n_errors++;
            $display("%s: ack or rdata changed while req was still high", cur_test);
        end
    end
    req = 1'b0;
    while (ack) begin
        @(posedge clk);
        #(DRIVE_DLY);
    end
endtask

task automatic run_and_check(input addr_t a, input logic r, input dsn_t d, input data_t wd);
    logic [6:0] sel;
    sel = expect_sel(a, r, d);
    bus_cycle(a, r, d, wd);
    check_value("chip selects", sel, last_seen);
    if (sel[6]) begin
        check_value("rom_addr", expect_rom_addr(board, a), last_rom_addr);
    end
    if (sel[3:0] != '0) begin
        check_value("select length", FIXED_WAIT, last_cs_cycles);
    end
    if (r || sel == '0) begin
        check_value("rdata", expect_rdata(a, sel), last_rdata);
    end
    check_value("bus_rnw", r, last_bus_rnw);
    if (!r) begin
        check_value("bus_dsn", d, last_bus_dsn);
        check_value("bus_dout", wd, last_bus_dout);
    end
    // Region 2 write with LDS loads the tile bank half picked by A1
    if (a[23:21] == REG_ROM2 && !r && !d[0]) begin
        if (a[1]) begin
            exp_tile[5:3] = wd[2:0];
        end else begin
            exp_tile[2:0] = wd[2:0];
        end
    end
    check_value("tile_bank", exp_tile, tile_bank);
endtask

task automatic test_reset_state();
    cur_test = "reset_state";
    check_value("ack", 0, ack);
    check_value("chip selects", 0, cs_now());
    check_value("tile_bank", 0, tile_bank);
    check_value("rdata", 0, rdata);
endtask

task automatic test_region_selects();
    addr_t a;
    cur_test = "region_selects";
    // Every strobe pattern on RAM and tile RAM
    for (int i = 0; i < 4; i++) begin
        run_and_check(rand_addr(REG_RAM), 1'b1, dsn_t'(i), '0);
        a = rand_addr(REG_VRAM);
        a[16] = 1'b0;
        run_and_check(a, 1'b1, dsn_t'(i), '0);
    end
    a = rand_addr(REG_VRAM);
    a[16] = 1'b1;
    run_and_check(a, 1'b1, 2'b00, '0);
    run_and_check(rand_addr(REG_ORAM), 1'b1, 2'b00, '0);
    run_and_check(rand_addr(REG_PAL), 1'b1, 2'b00, '0);
    run_and_check(rand_addr(REG_IO), 1'b1, 2'b00, '0);
endtask

task automatic test_rom_banking();
    cur_test = "rom_banking";
    for (int b = 0; b < 4; b++) begin
        @(posedge clk);
        #(DRIVE_DLY);
        board = board_e'(b);
        for (int r = 0; r < 3; r++) begin
            run_and_check(rand_addr(3'(r)), 1'b1, 2'b00, '0);
        end
    end
    // Writes to ROM select nothing
    run_and_check(rand_addr(REG_ROM1), 1'b0, 2'b00, 16'($urandom()));
endtask

task automatic test_read_data();
    cur_test = "read_data";
    repeat (16) begin
        run_and_check(rand_addr(3'($urandom_range(7, 2))), 1'b1, 2'b00, '0);
    end
    // Slow memories
    ok_min = 6;
    ok_max = OK_WAIT_LIMIT;
    for (int i = 0; i < 4; i++) begin
        run_and_check(rand_addr(i[0] ? REG_RAM : REG_ROM2), 1'b1, 2'b00, '0);
        assert (last_cycles > ok_min) else begin
            n_errors++;
            $display("%s: cycle finished before the delayed ok", cur_test);
        end
    end
    ok_min = 0;
    ok_max = 3;
endtask

task automatic test_tile_bank();
    addr_t a;
    data_t wd;
    cur_test = "tile_bank";
    a = rand_addr(REG_ROM2);
    a[1] = 1'b0;
    wd = 16'($urandom());
    wd[2:0] = exp_tile[2:0] ^ 3'($urandom_range(7, 1));
    run_and_check(a, 1'b0, 2'b10, wd);
    a[1] = 1'b1;
    wd = 16'($urandom());
    wd[2:0] = exp_tile[5:3] ^ 3'($urandom_range(7, 1));
    run_and_check(a, 1'b0, 2'b10, wd);
    // Upper strobe alone leaves the register unchanged
    wd[2:0] = ~exp_tile[5:3];
    run_and_check(a, 1'b0, 2'b01, wd);
    a[1] = 1'b0;
    wd[2:0] = ~exp_tile[2:0];
    run_and_check(a, 1'b0, 2'b01, wd);
endtask

`endif

// ==== test/tb_s16_main_bus.sv ====
/*
 * Testbench for the System 16B main bus controller
 * Clock, reset, device models, watchdog and the directed test sequence
 */
`default_nettype none

module tb_s16_main_bus;

    import s16_bus_pkg::*;
    import s16_map_pkg::*;

    localparam int CLK_PERIOD     = 20;
    localparam int RESET_CYCLES   = 10;
    localparam int DRIVE_DLY      = 1;
    localparam int MODEL_DLY      = 2;
    localparam int FIXED_WAIT     = 2;
    localparam int RNG_SEED       = 61296;
    localparam int OK_WAIT_LIMIT  = 9;
    // Watchdog bounds for about 50 bus cycles
    localparam int MAX_BUS_CYCLES = 64;
    localparam int MAX_CYCLE_LEN  = 12 + FIXED_WAIT + OK_WAIT_LIMIT;
    localparam int WATCHDOG_TIME  =
        (RESET_CYCLES + MAX_BUS_CYCLES * MAX_CYCLE_LEN) * CLK_PERIOD;

    // Tags in the upper nibble of each device model word
    localparam logic [3:0] TAG_RAM  = 4'ha;
    localparam logic [3:0] TAG_CHAR = 4'hc;
    localparam logic [3:0] TAG_OBJ  = 4'h4;
    localparam logic [3:0] TAG_PAL  = 4'h6;

    logic       clk;
    logic       rst;
    logic       req;
    logic       ack;
    addr_t      addr;
    logic       rnw;
    dsn_t       dsn;
    data_t      wdata;
    data_t      rdata;
    board_e     board;
    logic       rom_cs;
    logic       ram_cs;
    logic       vram_cs;
    logic       char_cs;
    logic       objram_cs;
    logic       pal_cs;
    logic       io_cs;
    rom_addr_t  rom_addr;
    data_t      rom_data;
    data_t      ram_data;
    data_t      char_dout;
    data_t      obj_dout;
    data_t      pal_dout;
    logic [7:0] io_dout;
    logic       rom_ok;
    logic       ram_ok;
    tile_bank_t tile_bank;
    logic [11:0] bus_addr;
    logic       bus_rnw;
    dsn_t       bus_dsn;
    data_t      bus_dout;

    int         n_checks;
    int         n_errors;
    string      cur_test;
    int         ok_min;
    int         ok_max;
    int         ok_wait;
    tile_bank_t exp_tile;

    // Results of the last bus cycle
    data_t      last_rdata;
    logic [6:0] last_seen;
    rom_addr_t  last_rom_addr;
    int         last_cycles;
    int         last_cs_cycles;
    logic       last_bus_rnw;
    dsn_t       last_bus_dsn;
    data_t      last_bus_dout;

    // ROM model word that depends on every address bit
    function automatic data_t rom_word(input rom_addr_t a);
        return {a[16:15] ^ a[18:17], a[14:1]} ^ 16'h5a00;
    endfunction

    function automatic logic [7:0] io_byte(input logic [11:0] a);
        return a[7:0] ^ {a[11:8], a[11:8]} ^ 8'h3c;
    endfunction

    `include "s16_bus_tasks.svh"

    s16_main_bus #(
        .FIXED_WAIT (FIXED_WAIT)
    ) u_s16_main_bus (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .ack       (ack),
        .addr      (addr),
        .rnw       (rnw),
        .dsn       (dsn),
        .wdata     (wdata),
        .rdata     (rdata),
        .board     (board),
        .rom_cs    (rom_cs),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .char_cs   (char_cs),
        .objram_cs (objram_cs),
        .pal_cs    (pal_cs),
        .io_cs     (io_cs),
        .rom_addr  (rom_addr),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .obj_dout  (obj_dout),
        .pal_dout  (pal_dout),
        .io_dout   (io_dout),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .tile_bank (tile_bank),
        .bus_addr  (bus_addr),
        .bus_rnw   (bus_rnw),
        .bus_dsn   (bus_dsn),
        .bus_dout  (bus_dout)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Device models answer from the address and raise ok after a random delay
    always @(posedge clk) begin
        #(MODEL_DLY);
        rom_data  = rom_word(rom_addr);
        ram_data  = {TAG_RAM, bus_addr};
        char_dout = {TAG_CHAR, bus_addr};
        obj_dout  = {TAG_OBJ, bus_addr};
        pal_dout  = {TAG_PAL, bus_addr};
        io_dout   = io_byte(bus_addr);
        if (rom_cs || ram_cs || vram_cs) begin
            if (ok_wait == 0) begin
                rom_ok = rom_cs;
                ram_ok = ram_cs || vram_cs;
            end else begin
                ok_wait--;
            end
        end else begin
            rom_ok  = 1'b0;
            ram_ok  = 1'b0;
            ok_wait = $urandom_range(ok_max, ok_min);
        end
    end

    initial begin : watchdog
        #(WATCHDOG_TIME);
        $display("watchdog expired, a bus cycle never completed");
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(RNG_SEED));
        clk       = 1'b0;
        rst       = 1'b1;
        req       = 1'b0;
        addr      = '0;
        rnw       = 1'b1;
        dsn       = 2'b11;
        wdata     = '0;
        board     = BOARD_5521;
        rom_data  = '0;
        ram_data  = '0;
        char_dout = '0;
        obj_dout  = '0;
        pal_dout  = '0;
        io_dout   = '0;
        rom_ok    = 1'b0;
        ram_ok    = 1'b0;
        n_checks  = 0;
        n_errors  = 0;
        ok_min    = 0;
        ok_max    = 3;
        ok_wait   = 0;
        exp_tile  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        rst = 1'b0;

        test_reset_state();
        test_region_selects();
        test_rom_banking();
        test_read_data();
        test_tile_bank();

        $display("%0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
